// ==== list.f ====
+incdir+design
design/cpu_pkg.sv
design/cpu_decode.sv
design/cpu_execute.sv
design/cpu_result.sv
design/cpu_core.sv
design/axi_lite_master.sv
design/cpu_wrapper.sv
verification/axi_lite_mem_model.sv
verification/tb_cpu_wrapper.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_cpu_wrapper
FILELIST  = list.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== verification/tb_cpu_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module tb_cpu_wrapper;

  localparam int MEM_WORDS = 256;
  localparam cpu_pkg::word_t EBREAK = 32'h0010_0073;

  // funct3 values of the subset
  localparam logic [2:0] F3_BYTE  = 3'b000;
  localparam logic [2:0] F3_WORD  = 3'b010;
  localparam logic [2:0] F3_BYTEU = 3'b100;
  localparam logic [2:0] F3_BEQ   = 3'b000;
  localparam logic [2:0] F3_BNE   = 3'b001;

  logic              clk;
  logic              reset_i;
  logic              delay_en;
  logic              halt;
  cpu_pkg::axi_req_t imem_axi_req;
  cpu_pkg::axi_rsp_t imem_axi_rsp;
  cpu_pkg::axi_req_t dmem_axi_req;
  cpu_pkg::axi_rsp_t dmem_axi_rsp;

  int unsigned    mismatches;
  int unsigned    failures;
  int unsigned    cycle_count;
  int unsigned    cycle_limit;
  int unsigned    first_read;
  cpu_pkg::word_t prog [$];

  cpu_wrapper i_dut (
    .clk        (clk),
    .reset_i    (reset_i),
    .imem_axi_o (imem_axi_req),
    .imem_axi_i (imem_axi_rsp),
    .dmem_axi_o (dmem_axi_req),
    .dmem_axi_i (dmem_axi_rsp),
    .halt_o     (halt)
  );

  // Program memory
  axi_lite_mem_model i_imem (
    .clk        (clk),
    .reset_i    (reset_i),
    .delay_en_i (delay_en),
    .axi_i      (imem_axi_req),
    .axi_o      (imem_axi_rsp)
  );

  // Data memory
  axi_lite_mem_model i_dmem (
    .clk        (clk),
    .reset_i    (reset_i),
    .delay_en_i (delay_en),
    .axi_i      (dmem_axi_req),
    .axi_o      (dmem_axi_rsp)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // Watchdog, the limit grows with every program run
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run passed its limit of %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // RV32I encodings
  function automatic cpu_pkg::word_t addi(int rd, int rs1, int imm);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic cpu_pkg::word_t r_op(logic [6:0] funct7, logic [2:0] funct3,
                                          int rd, int rs1, int rs2);
    return {funct7, 5'(rs2), 5'(rs1), funct3, 5'(rd), 7'b0110011};
  endfunction

  function automatic cpu_pkg::word_t load(logic [2:0] funct3, int rd, int rs1, int imm);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12, 5'(rs1), funct3, 5'(rd), 7'b0000011};
  endfunction

  function automatic cpu_pkg::word_t store(logic [2:0] funct3, int rs2, int rs1, int imm);
    logic [11:0] i12;
    i12 = 12'(imm);
    return {i12[11:5], 5'(rs2), 5'(rs1), funct3, i12[4:0], 7'b0100011};
  endfunction

  function automatic cpu_pkg::word_t branch(logic [2:0] funct3, int rs1, int rs2, int offset);
    logic [12:0] o13;
    o13 = 13'(offset);
    return {o13[12], o13[10:5], 5'(rs2), 5'(rs1), funct3, o13[4:1], o13[11], 7'b1100011};
  endfunction

  // Background word, differs for every address
  function automatic cpu_pkg::word_t fill_word(int idx);
    return 32'hC0DE_0000 ^ (idx * 4);
  endfunction

  function automatic cpu_pkg::word_t dmem_word(int byte_addr);
    return i_dmem.mem[byte_addr >> 2];
  endfunction

  task automatic check_word(cpu_pkg::word_t actual, cpu_pkg::word_t expected, string what);
    if (actual !== expected) begin
      mismatches++;
      $display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_strb(cpu_pkg::strb_t actual, cpu_pkg::strb_t expected, string what);
    if (actual !== expected) begin
      mismatches++;
      $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_bit(logic actual, logic expected, string what);
    if (actual !== expected) begin
      mismatches++;
      $display("CHECK FAILED at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic fill_data();
    for (int i = 0; i < MEM_WORDS; i++) begin
      i_dmem.mem[i] = fill_word(i);
    end
  endtask

  // Program first, background after it
  task automatic load_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      i_imem.mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
    end
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    repeat (5) begin
      @(posedge clk);
      #1;
      check_bit(imem_axi_req.ar_valid | imem_axi_req.aw_valid | imem_axi_req.w_valid |
                dmem_axi_req.ar_valid | dmem_axi_req.aw_valid | dmem_axi_req.w_valid,
                1'b0, "valid during reset");
    end
    reset_i = 1'b0;
  endtask

  // Reset, run to halt, then watch the fetch port stay quiet
  task automatic run_program();
    int unsigned budget;
    int unsigned waited;
    int unsigned reads;
    budget      = prog.size() * 20;
    cycle_limit = cycle_limit + budget + 100;
    first_read  = i_imem.read_count;
    load_program();
    apply_reset();
    waited = 0;
    while (!halt && (waited < budget)) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!halt) begin
      failures++;
      $display("halt_o never rose within %0d cycles at %0t ns", budget, $time);
      return;
    end
    check_word(i_imem.read_log[first_read], `CPU_RESET_PC, "first fetch address");
    reads = i_imem.read_count;
    repeat (50) begin
      @(posedge clk);
      #1;
    end
    if (i_imem.read_count != reads) begin
      failures++;
      $display("Instruction read made after halt_o rose, at %0t ns", $time);
    end
    check_bit(halt, 1'b1, "halt_o held");
  endtask

  task automatic test_reset_fetch();
    prog.delete();
    prog.push_back(addi(1, 0, 1));
    prog.push_back(addi(2, 0, 2));
    prog.push_back(EBREAK);
    fill_data();
    run_program();
    check_word(i_imem.read_count - first_read, 32'd3, "fetch count");
    if (i_imem.read_count - first_read == 3) begin
      for (int i = 0; i < 3; i++) begin
        check_word(i_imem.read_log[first_read + i], `CPU_RESET_PC + 32'(4 * i),
                   $sformatf("fetch address %0d", i));
      end
    end
  endtask

  task automatic test_alu();
    cpu_pkg::word_t exp [8];
    // Operands 100 and -7, then sum, difference, AND, OR, XOR and x0
    exp = '{32'h0000_0064, 32'hFFFF_FFF9, 32'h0000_005D, 32'hFFFF_FF95,
            32'h0000_0060, 32'hFFFF_FFFD, 32'hFFFF_FF9D, 32'h0000_0000};
    prog.delete();
    prog.push_back(addi(1, 0, 100));
    prog.push_back(addi(2, 0, -7));
    prog.push_back(r_op(7'h00, 3'b000, 3, 1, 2));
    prog.push_back(r_op(7'h20, 3'b000, 4, 2, 1));
    prog.push_back(r_op(7'h00, 3'b111, 5, 1, 2));
    prog.push_back(r_op(7'h00, 3'b110, 6, 1, 2));
    prog.push_back(r_op(7'h00, 3'b100, 7, 1, 2));
    // Both aimed at x0
    prog.push_back(addi(0, 1, 5));
    prog.push_back(r_op(7'h00, 3'b000, 0, 1, 2));
    for (int r = 0; r < 8; r++) begin
      prog.push_back(store(F3_WORD, r + 1 == 8 ? 0 : r + 1, 0, 'h100 + 4 * r));
    end
    prog.push_back(EBREAK);
    fill_data();
    run_program();
    for (int i = 0; i < 8; i++) begin
      check_word(dmem_word('h100 + 4 * i), exp[i], $sformatf("ALU result %0d", i));
    end
  endtask

  task automatic test_loads();
    cpu_pkg::word_t src;
    cpu_pkg::word_t exp [6];
    src = 32'h8F7F_C1A2;
    exp = '{{{24{src[7]}}, src[7:0]}, {24'h0, src[15:8]}, {{24{src[23]}}, src[23:16]},
            {{24{src[31]}}, src[31:24]}, {24'h0, src[31:24]}, src};
    prog.delete();
    prog.push_back(load(F3_BYTE, 1, 0, 'h140));
    prog.push_back(load(F3_BYTEU, 2, 0, 'h141));
    prog.push_back(load(F3_BYTE, 3, 0, 'h142));
    prog.push_back(load(F3_BYTE, 4, 0, 'h143));
    prog.push_back(load(F3_BYTEU, 5, 0, 'h143));
    prog.push_back(load(F3_WORD, 6, 0, 'h140));
    for (int r = 1; r <= 6; r++) begin
      prog.push_back(store(F3_WORD, r, 0, 'h180 + 4 * (r - 1)));
    end
    prog.push_back(EBREAK);
    fill_data();
    i_dmem.mem['h140 >> 2] = src;
    run_program();
    for (int i = 0; i < 6; i++) begin
      check_word(dmem_word('h180 + 4 * i), exp[i], $sformatf("load result %0d", i));
    end
  endtask

  task automatic test_byte_stores();
    cpu_pkg::word_t vals [4];
    int unsigned    first_strb;
    vals = '{32'h3C1, 32'h0B2, 32'h7D3, 32'd0 - 32'd28};
    prog.delete();
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(addi(r, 0, int'(vals[r - 1])));
    end
    for (int r = 1; r <= 4; r++) begin
      prog.push_back(store(F3_BYTE, r, 0, 'h1C0 + r - 1));
    end
    prog.push_back(EBREAK);
    fill_data();
    first_strb = i_dmem.strb_log.size();
    run_program();
    // Low byte of each register lands in its own lane
    check_word(dmem_word('h1C0), {vals[3][7:0], vals[2][7:0], vals[1][7:0], vals[0][7:0]},
               "merged byte stores");
    check_word(dmem_word('h1C4), fill_word('h1C4 >> 2), "word after the byte stores");
    check_word(i_dmem.strb_log.size() - first_strb, 32'd4, "byte store count");
    if (i_dmem.strb_log.size() - first_strb == 4) begin
      for (int i = 0; i < 4; i++) begin
        check_strb(i_dmem.strb_log[first_strb + i], 4'(1 << i), $sformatf("strobe %0d", i));
      end
    end
  endtask

  task automatic test_branches();
    logic [7:0] ran;
    // Marker slots on the executed path
    ran = 8'b1110_1110;
    prog.delete();
    prog.push_back(addi(1, 0, 5));
    prog.push_back(addi(2, 0, 5));
    prog.push_back(addi(3, 0, 9));
    prog.push_back(addi(9, 0, 'h77));
    prog.push_back(branch(F3_BEQ, 1, 2, 8));
    prog.push_back(store(F3_WORD, 9, 0, 'h200));
    prog.push_back(store(F3_WORD, 9, 0, 'h204));
    prog.push_back(branch(F3_BEQ, 1, 3, 8));
    prog.push_back(store(F3_WORD, 9, 0, 'h208));
    prog.push_back(store(F3_WORD, 9, 0, 'h20C));
    prog.push_back(branch(F3_BNE, 1, 3, 8));
    prog.push_back(store(F3_WORD, 9, 0, 'h210));
    prog.push_back(store(F3_WORD, 9, 0, 'h214));
    prog.push_back(branch(F3_BNE, 1, 2, 8));
    prog.push_back(store(F3_WORD, 9, 0, 'h218));
    prog.push_back(store(F3_WORD, 9, 0, 'h21C));
    prog.push_back(EBREAK);
    fill_data();
    run_program();
    for (int k = 0; k < 8; k++) begin
      check_word(dmem_word('h200 + 4 * k), ran[k] ? 32'h77 : fill_word(('h200 >> 2) + k),
                 $sformatf("branch marker %0d", k));
    end
  endtask

  initial begin
    void'($urandom(93));
    reset_i     = 1'b1;
    delay_en    = 1'b0;
    mismatches  = 0;
    failures    = 0;
    cycle_count = 0;
    cycle_limit = 0;
    test_reset_fetch();
    test_alu();
    test_loads();
    test_byte_stores();
    test_branches();
    // Same programs under random back-pressure
    delay_en = 1'b1;
    test_alu();
    test_loads();
    test_byte_stores();
    test_branches();
    $display("Value mismatches: %0d, other failures: %0d", mismatches, failures);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/axi_lite_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_mem_model (
  input  logic              clk,
  input  logic              reset_i,
  input  logic              delay_en_i,
  input  cpu_pkg::axi_req_t axi_i,
  output cpu_pkg::axi_rsp_t axi_o
);

  localparam int MEM_WORDS = 256;

  // Word storage, indexed by address bits [9:2]
  cpu_pkg::word_t mem [MEM_WORDS];
  // Strobe of every accepted write, oldest first
  cpu_pkg::strb_t strb_log [$];
  // Address of every accepted read
  cpu_pkg::word_t read_log [$];
  int unsigned    read_count;

  // Outputs move 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Random wait of 0 to 3 cycles when back-pressure is on
  function automatic int unsigned pick_delay();
    if (delay_en_i) begin
      return $urandom_range(3, 0);
    end
    return 0;
  endfunction

  task automatic serve_read();
    cpu_pkg::word_t addr;
    repeat (pick_delay()) next_cycle();
    addr           = axi_i.ar_addr;
    axi_o.ar_ready = 1'b1;
    next_cycle();
    axi_o.ar_ready = 1'b0;
    read_count++;
    read_log.push_back(addr);
    repeat (pick_delay()) next_cycle();
    axi_o.r_data  = mem[addr[9:2]];
    axi_o.r_valid = 1'b1;
    while (!axi_i.r_ready) begin
      next_cycle();
    end
    next_cycle();
    axi_o.r_valid = 1'b0;
  endtask

  task automatic serve_write();
    cpu_pkg::word_t addr;
    cpu_pkg::word_t data;
    cpu_pkg::strb_t strb;
    int unsigned    aw_wait;
    int unsigned    w_wait;
    int unsigned    cycles;
    logic           aw_taken;
    logic           w_taken;
    aw_wait  = pick_delay();
    w_wait   = pick_delay();
    cycles   = 0;
    aw_taken = 1'b0;
    w_taken  = 1'b0;
    addr     = '0;
    data     = '0;
    strb     = '0;
    // AW and W accepted independently, possibly in the same cycle
    while (!(aw_taken && w_taken)) begin
      axi_o.aw_ready = !aw_taken && (cycles >= aw_wait);
      axi_o.w_ready  = !w_taken && (cycles >= w_wait);
      if (axi_o.aw_ready) begin
        addr = axi_i.aw_addr;
      end
      if (axi_o.w_ready) begin
        data = axi_i.w_data;
        strb = axi_i.w_strb;
      end
      next_cycle();
      aw_taken = aw_taken || axi_o.aw_ready;
      w_taken  = w_taken || axi_o.w_ready;
      cycles++;
    end
    axi_o.aw_ready = 1'b0;
    axi_o.w_ready  = 1'b0;
    // Only strobed lanes change
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        mem[addr[9:2]][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    strb_log.push_back(strb);
    repeat (pick_delay()) next_cycle();
    axi_o.b_valid = 1'b1;
    while (!axi_i.b_ready) begin
      next_cycle();
    end
    next_cycle();
    axi_o.b_valid = 1'b0;
  endtask

  // One transaction at a time, the master never overlaps them
  initial begin
    axi_o      = '0;
    read_count = 0;
    forever begin
      next_cycle();
      if (!reset_i && axi_i.ar_valid) begin
        serve_read();
      end else if (!reset_i && axi_i.aw_valid) begin
        serve_write();
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_wrapper (
  input  logic              clk,
  input  logic              reset_i,
  output cpu_pkg::axi_req_t imem_axi_o,
  input  cpu_pkg::axi_rsp_t imem_axi_i,
  output cpu_pkg::axi_req_t dmem_axi_o,
  input  cpu_pkg::axi_rsp_t dmem_axi_i,
  output logic              halt_o
);

  // Core side of the two masters
  cpu_pkg::mem_req_t imem_req;
  cpu_pkg::mem_rsp_t imem_rsp;
  cpu_pkg::mem_req_t dmem_req;
  cpu_pkg::mem_rsp_t dmem_rsp;

  cpu_core i_core (
    .clk        (clk),
    .reset_i    (reset_i),
    .imem_req_o (imem_req),
    .imem_rsp_i (imem_rsp),
    .dmem_req_o (dmem_req),
    .dmem_rsp_i (dmem_rsp),
    .halt_o     (halt_o)
  );

  // Instruction fetch port, read only
  axi_lite_master i_imem_master (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (imem_req),
    .rsp_o   (imem_rsp),
    .axi_o   (imem_axi_o),
    .axi_i   (imem_axi_i)
  );

  // Load and store port
  axi_lite_master i_dmem_master (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (dmem_req),
    .rsp_o   (dmem_rsp),
    .axi_o   (dmem_axi_o),
    .axi_i   (dmem_axi_i)
  );

endmodule

`default_nettype wire

// ==== design/axi_lite_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_lite_master (
  input  logic              clk,
  input  logic              reset_i,
  input  cpu_pkg::mem_req_t req_i,
  output cpu_pkg::mem_rsp_t rsp_o,
  output cpu_pkg::axi_req_t axi_o,
  input  cpu_pkg::axi_rsp_t axi_i
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_RADDR,
    ST_RDATA,
    ST_WRITE,
    ST_WRESP,
    ST_DONE
  } master_state_e;

  master_state_e  state_q;
  logic           aw_done_q;
  logic           w_done_q;
  cpu_pkg::word_t addr_q;
  cpu_pkg::word_t wdata_q;
  cpu_pkg::strb_t strb_q;
  cpu_pkg::word_t rdata_q;
  logic           aw_fire;
  logic           w_fire;
  logic           aw_ok;
  logic           w_ok;

  // Channel outputs follow the state and the latched request
  always_comb begin
    axi_o          = '0;
    axi_o.ar_valid = (state_q == ST_RADDR);
    axi_o.ar_addr  = addr_q;
    axi_o.r_ready  = (state_q == ST_RDATA);
    axi_o.aw_valid = (state_q == ST_WRITE) && !aw_done_q;
    axi_o.aw_addr  = addr_q;
    axi_o.w_valid  = (state_q == ST_WRITE) && !w_done_q;
    axi_o.w_data   = wdata_q;
    axi_o.w_strb   = strb_q;
    axi_o.b_ready  = (state_q == ST_WRESP);
  end

  assign aw_fire = axi_o.aw_valid && axi_i.aw_ready;
  assign w_fire  = axi_o.w_valid && axi_i.w_ready;
  // AW and W may finish in either order or together
  assign aw_ok   = aw_done_q || aw_fire;
  assign w_ok    = w_done_q || w_fire;

  // Stall from acceptance until the done cycle
  assign rsp_o.stall = (state_q == ST_IDLE) ? req_i.req : (state_q != ST_DONE);
  assign rsp_o.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q   <= ST_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          aw_done_q <= 1'b0;
          w_done_q  <= 1'b0;
          if (req_i.req) begin
            state_q <= req_i.write ? ST_WRITE : ST_RADDR;
          end
        end
        ST_RADDR: begin
          if (axi_i.ar_ready) begin
            state_q <= ST_RDATA;
          end
        end
        ST_RDATA: begin
          if (axi_i.r_valid) begin
            state_q <= ST_DONE;
          end
        end
        ST_WRITE: begin
          aw_done_q <= aw_ok;
          w_done_q  <= w_ok;
          if (aw_ok && w_ok) begin
            state_q <= ST_WRESP;
          end
        end
        ST_WRESP: begin
          // Response code is not checked
          if (axi_i.b_valid) begin
            state_q <= ST_DONE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Request payload taken once, when the request is accepted
  always_ff @(posedge clk) begin
    if ((state_q == ST_IDLE) && req_i.req) begin
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
      strb_q  <= req_i.strb;
    end
    if ((state_q == ST_RDATA) && axi_i.r_valid) begin
      rdata_q <= axi_i.r_data;
    end
  end

  // Valid stays up with a stable payload until the slave takes it
  a_ar_hold: assert property (@(posedge clk) disable iff (reset_i)
    (axi_o.ar_valid && !axi_i.ar_ready) |=> (axi_o.ar_valid && $stable(axi_o.ar_addr)));

  a_aw_hold: assert property (@(posedge clk) disable iff (reset_i)
    (axi_o.aw_valid && !axi_i.aw_ready) |=> (axi_o.aw_valid && $stable(axi_o.aw_addr)));

  a_w_hold: assert property (@(posedge clk) disable iff (reset_i)
    (axi_o.w_valid && !axi_i.w_ready) |=> (axi_o.w_valid && $stable(axi_o.w_data)));

endmodule

`default_nettype wire

// ==== design/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
  input  logic              clk,
  input  logic              reset_i,
  output cpu_pkg::mem_req_t imem_req_o,
  input  cpu_pkg::mem_rsp_t imem_rsp_i,
  output cpu_pkg::mem_req_t dmem_req_o,
  input  cpu_pkg::mem_rsp_t dmem_rsp_i,
  output logic              halt_o
);

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } core_state_e;

  core_state_e       state_q;
  cpu_pkg::word_t    pc_q;
  cpu_pkg::instr_u   ir_q;
  cpu_pkg::decoded_t dec;
  cpu_pkg::word_t    rs1_val;
  cpu_pkg::word_t    rs2_val;
  cpu_pkg::word_t    alu_res;
  cpu_pkg::word_t    branch_target;
  logic              branch_taken;
  cpu_pkg::mem_req_t exe_dmem_req;
  logic              mem_op;
  logic              stop;
  logic              wb_en;

  cpu_decode i_decode (
    .instr_i (ir_q),
    .dec_o   (dec)
  );

  cpu_execute i_execute (
    .dec_i           (dec),
    .rs1_val_i       (rs1_val),
    .rs2_val_i       (rs2_val),
    .pc_i            (pc_q),
    .alu_res_o       (alu_res),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target),
    .dmem_req_o      (exe_dmem_req)
  );

  // Low address bits select the load byte lane
  cpu_result i_result (
    .clk           (clk),
    .reset_i       (reset_i),
    .dec_i         (dec),
    .rs1_o         (rs1_val),
    .rs2_o         (rs2_val),
    .alu_res_i     (alu_res),
    .load_data_i   (dmem_rsp_i.rdata),
    .load_offset_i (alu_res[1:0]),
    .wb_en_i       (wb_en)
  );

  assign mem_op = dec.is_load | dec.is_store;
  // Illegal encodings stop the core like EBREAK
  assign stop   = dec.is_halt | dec.illegal;

  // ALU ops write in EXEC, loads in the MEM completion cycle
  assign wb_en = ((state_q == ST_EXEC) && !stop && !mem_op) ||
                 ((state_q == ST_MEM) && !dmem_rsp_i.stall);

  // Fetch port never writes
  always_comb begin
    imem_req_o      = '0;
    imem_req_o.req  = (state_q == ST_FETCH);
    imem_req_o.addr = pc_q;
  end

  // Fields come from execute, request only in MEM
  always_comb begin
    dmem_req_o     = exe_dmem_req;
    dmem_req_o.req = exe_dmem_req.req && (state_q == ST_MEM);
  end

  assign halt_o = (state_q == ST_HALT);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= ST_FETCH;
      pc_q    <= `CPU_RESET_PC;
    end else begin
      case (state_q)
        ST_FETCH: begin
          if (!imem_rsp_i.stall) begin
            state_q <= ST_EXEC;
          end
        end
        ST_EXEC: begin
          if (stop) begin
            state_q <= ST_HALT;
          end else if (mem_op) begin
            state_q <= ST_MEM;
          end else begin
            state_q <= ST_FETCH;
            pc_q    <= branch_taken ? branch_target : pc_q + `CPU_PC_STEP;
          end
        end
        ST_MEM: begin
          if (!dmem_rsp_i.stall) begin
            state_q <= ST_FETCH;
            pc_q    <= pc_q + `CPU_PC_STEP;
          end
        end
        default: state_q <= ST_HALT;
      endcase
    end
  end

  // Instruction register loads on fetch completion
  always_ff @(posedge clk) begin
    if ((state_q == ST_FETCH) && !imem_rsp_i.stall) begin
      ir_q <= imem_rsp_i.rdata;
    end
  end

  // Branch targets and sequential steps keep the PC word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
    pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== design/cpu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_result (
  input  logic              clk,
  input  logic              reset_i,
  input  cpu_pkg::decoded_t dec_i,
  output cpu_pkg::word_t    rs1_o,
  output cpu_pkg::word_t    rs2_o,
  input  cpu_pkg::word_t    alu_res_i,
  input  cpu_pkg::word_t    load_data_i,
  input  logic [1:0]        load_offset_i,
  input  logic              wb_en_i
);

  cpu_pkg::word_t regs [`CPU_REG_COUNT];
  logic [4:0]     lane_shift;
  logic [7:0]     load_byte;
  cpu_pkg::word_t load_val;
  cpu_pkg::word_t wb_data;

  // x0 reads as zero whatever the array holds
  assign rs1_o = (dec_i.rs1 == '0) ? '0 : regs[dec_i.rs1];
  assign rs2_o = (dec_i.rs2 == '0) ? '0 : regs[dec_i.rs2];

  // Byte lane picked by the low address bits
  assign lane_shift = {load_offset_i, 3'b000};
  assign load_byte  = load_data_i[lane_shift +: 8];

  always_comb begin
    if (dec_i.mem_size == cpu_pkg::MEM_WORD) begin
      load_val = load_data_i;
    end else if (dec_i.load_unsigned) begin
      load_val = {24'h0, load_byte};
    end else begin
      // LB sign extends
      load_val = {{24{load_byte[7]}}, load_byte};
    end
  end

  assign wb_data = dec_i.is_load ? load_val : alu_res_i;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < `CPU_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && dec_i.reg_write && (dec_i.rd != '0)) begin
      regs[dec_i.rd] <= wb_data;
    end
  end

  // Writes aimed at x0 are dropped
  a_x0_zero: assert property (@(posedge clk) disable iff (reset_i)
    (wb_en_i && dec_i.reg_write && (dec_i.rd == '0)) |=> (regs[0] == '0));

endmodule

`default_nettype wire

// ==== design/cpu_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_execute (
  input  cpu_pkg::decoded_t dec_i,
  input  cpu_pkg::word_t    rs1_val_i,
  input  cpu_pkg::word_t    rs2_val_i,
  input  cpu_pkg::word_t    pc_i,
  output cpu_pkg::word_t    alu_res_o,
  output logic              branch_taken_o,
  output cpu_pkg::word_t    branch_target_o,
  output cpu_pkg::mem_req_t dmem_req_o
);

  cpu_pkg::word_t op_b;
  logic           is_byte;

  // Second operand is the immediate for ADDI, loads and stores
  assign op_b = dec_i.use_imm ? dec_i.imm : rs2_val_i;

  always_comb begin
    case (dec_i.alu_op)
      cpu_pkg::ALU_ADD: alu_res_o = rs1_val_i + op_b;
      cpu_pkg::ALU_SUB: alu_res_o = rs1_val_i - op_b;
      cpu_pkg::ALU_AND: alu_res_o = rs1_val_i & op_b;
      cpu_pkg::ALU_OR:  alu_res_o = rs1_val_i | op_b;
      cpu_pkg::ALU_XOR: alu_res_o = rs1_val_i ^ op_b;
      default:          alu_res_o = rs1_val_i + op_b;
    endcase
  end

  // Branch compare on the raw register values
  assign branch_taken_o  = dec_i.is_branch &
                           (dec_i.branch_ne ? (rs1_val_i != rs2_val_i)
                                            : (rs1_val_i == rs2_val_i));
  assign branch_target_o = pc_i + dec_i.imm;

  assign is_byte = (dec_i.mem_size == cpu_pkg::MEM_BYTE);

  // Effective address is the ALU sum, loads and stores decode to ADD
  always_comb begin
    dmem_req_o       = '0;
    dmem_req_o.req   = dec_i.is_load | dec_i.is_store;
    dmem_req_o.write = dec_i.is_store;
    // Bus always sees the word address, lanes pick the byte
    dmem_req_o.addr  = {alu_res_o[31:2], 2'b00};
    if (is_byte) begin
      // Byte copied to every lane, strobe selects the one that counts
      dmem_req_o.wdata = {4{rs2_val_i[7:0]}};
      dmem_req_o.strb  = 4'b0001 << alu_res_o[1:0];
    end else begin
      dmem_req_o.wdata = rs2_val_i;
      dmem_req_o.strb  = 4'b1111;
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_decode (
  input  cpu_pkg::instr_u   instr_i,
  output cpu_pkg::decoded_t dec_o
);

  cpu_pkg::word_t imm_i;
  cpu_pkg::word_t imm_s;
  cpu_pkg::word_t imm_b;

  // I immediate from the R/I view
  assign imm_i = {{20{instr_i.ri.funct7[6]}}, instr_i.ri.funct7, instr_i.ri.rs2};

  // S immediate from the S/B view
  assign imm_s = {{20{instr_i.sb.imm_hi[6]}}, instr_i.sb.imm_hi, instr_i.sb.imm_lo};

  // B immediate, bit 11 sits in imm_lo[0] and bit 0 is always zero
  assign imm_b = {{20{instr_i.sb.imm_hi[6]}}, instr_i.sb.imm_lo[0],
                  instr_i.sb.imm_hi[5:0], instr_i.sb.imm_lo[4:1], 1'b0};

  always_comb begin
    dec_o          = '0;
    dec_o.alu_op   = cpu_pkg::ALU_ADD;
    dec_o.mem_size = cpu_pkg::MEM_WORD;
    // Register fields sit in the same place in both views
    dec_o.rs1      = instr_i.ri.rs1;
    dec_o.rs2      = instr_i.ri.rs2;
    dec_o.rd       = instr_i.ri.rd;
    case (instr_i.ri.opcode)
      cpu_pkg::OPC_OP: begin
        dec_o.reg_write = 1'b1;
        case ({instr_i.ri.funct7, instr_i.ri.funct3})
          {7'b0000000, 3'b000}: dec_o.alu_op = cpu_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: dec_o.alu_op = cpu_pkg::ALU_SUB;
          {7'b0000000, 3'b111}: dec_o.alu_op = cpu_pkg::ALU_AND;
          {7'b0000000, 3'b110}: dec_o.alu_op = cpu_pkg::ALU_OR;
          {7'b0000000, 3'b100}: dec_o.alu_op = cpu_pkg::ALU_XOR;
          default:              dec_o.illegal = 1'b1;
        endcase
      end
      cpu_pkg::OPC_OP_IMM: begin
        // ADDI only
        dec_o.reg_write = 1'b1;
        dec_o.use_imm   = 1'b1;
        dec_o.imm       = imm_i;
        dec_o.illegal   = (instr_i.ri.funct3 != 3'b000);
      end
      cpu_pkg::OPC_LOAD: begin
        dec_o.reg_write     = 1'b1;
        dec_o.use_imm       = 1'b1;
        dec_o.imm           = imm_i;
        dec_o.is_load       = 1'b1;
        dec_o.load_unsigned = instr_i.ri.funct3[2];
        case (instr_i.ri.funct3)
          3'b000:  dec_o.mem_size = cpu_pkg::MEM_BYTE;
          3'b100:  dec_o.mem_size = cpu_pkg::MEM_BYTE;
          3'b010:  dec_o.mem_size = cpu_pkg::MEM_WORD;
          default: dec_o.illegal  = 1'b1;
        endcase
      end
      cpu_pkg::OPC_STORE: begin
        dec_o.use_imm  = 1'b1;
        dec_o.imm      = imm_s;
        dec_o.is_store = 1'b1;
        case (instr_i.sb.funct3)
          3'b000:  dec_o.mem_size = cpu_pkg::MEM_BYTE;
          3'b010:  dec_o.mem_size = cpu_pkg::MEM_WORD;
          default: dec_o.illegal  = 1'b1;
        endcase
      end
      cpu_pkg::OPC_BRANCH: begin
        // BEQ and BNE differ only in funct3[0]
        dec_o.imm       = imm_b;
        dec_o.is_branch = 1'b1;
        dec_o.branch_ne = instr_i.sb.funct3[0];
        dec_o.illegal   = (instr_i.sb.funct3[2:1] != 2'b00);
      end
      cpu_pkg::OPC_SYSTEM: begin
        dec_o.is_halt = (instr_i == `CPU_EBREAK_WORD);
        dec_o.illegal = (instr_i != `CPU_EBREAK_WORD);
      end
      default: dec_o.illegal = 1'b1;
    endcase
    // Nothing outside the subset may touch the register file
    if (dec_o.illegal) begin
      dec_o.reg_write = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== design/cpu_pkg.sv ====
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0]          word_t;
  typedef logic [`CPU_XLEN/8-1:0]        strb_t;
  typedef logic [`CPU_REG_ADDR_BITS-1:0] reg_idx_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR
  } alu_op_e;

  // Encoded like funct3 bits [1:0]
  typedef enum logic [1:0] {
    MEM_BYTE = 2'b00,
    MEM_WORD = 2'b10
  } mem_size_e;

  // R and I formats, funct7 doubles as imm[11:5] and rs2 as imm[4:0]
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_e    opcode;
  } instr_ri_t;

  // S and B formats, immediate split around the register fields
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } instr_sb_t;

  typedef union packed {
    instr_ri_t ri;
    instr_sb_t sb;
  } instr_u;

  typedef struct packed {
    alu_op_e   alu_op;
    logic      use_imm;
    word_t     imm;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    logic      reg_write;
    logic      is_load;
    logic      is_store;
    logic      load_unsigned;
    mem_size_e mem_size;
    logic      is_branch;
    logic      branch_ne;
    logic      is_halt;
    logic      illegal;
  } decoded_t;

  // Core side of a bus master
  typedef struct packed {
    logic  req;
    logic  write;
    word_t addr;
    word_t wdata;
    strb_t strb;
  } mem_req_t;

  typedef struct packed {
    word_t rdata;
    logic  stall;
  } mem_rsp_t;

  // AXI-lite master outputs
  typedef struct packed {
    logic  aw_valid;
    word_t aw_addr;
    logic  w_valid;
    word_t w_data;
    strb_t w_strb;
    logic  b_ready;
    logic  ar_valid;
    word_t ar_addr;
    logic  r_ready;
  } axi_req_t;

  // AXI-lite slave outputs
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    logic [1:0] b_resp;
    logic       ar_ready;
    logic       r_valid;
    word_t      r_data;
    logic [1:0] r_resp;
  } axi_rsp_t;

endpackage

`default_nettype wire

// ==== design/cpu_defines.svh ====
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width of the core and both buses
`define CPU_XLEN 32

// Register file size
`define CPU_REG_COUNT 32

// Register index width
`define CPU_REG_ADDR_BITS 5

// Address of the first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// PC increment for sequential flow
`define CPU_PC_STEP 32'd4

// EBREAK is matched on the whole word
`define CPU_EBREAK_WORD 32'h0010_0073

`endif
